//--- Makefile
# Verilator build for the framebuffer subsystem testbench

VERILATOR ?= verilator
TOP       ?= frameSubsystemTb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- common/framePkg.sv
`include "frameSettings_settings.svh"

package framePkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Plain vectors

    typedef logic [`SRAM_DATA_WIDTH-1:0]    Pixel_t;
    typedef logic [`SRAM_ADDRESS_WIDTH-1:0] SramAddress_t;
    typedef logic [`COORD_WIDTH-1:0]        Coord_t;
    typedef logic [`APB_ADDRESS_WIDTH-1:0]  ApbAddress_t;
    typedef logic [`APB_DATA_WIDTH-1:0]     ApbData_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // SRAM clients and pins

    typedef struct packed {
        SramAddress_t address;
        Pixel_t       writeData;
        logic         writeEnable;
        logic         valid;       // Stays up with the fields until done
    } SramRequest_t;

    typedef struct packed {
        Pixel_t readData;
        logic   done;
    } SramResult_t;

    // The pad is split so the board top owns the tristate
    typedef struct packed {
        SramAddress_t address;
        logic         weN;
        logic         oeN;
        Pixel_t       dataOut;
        logic         dataEnable;
    } SramBus_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // APB and the register map

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        ApbAddress_t paddr;
        ApbData_t    pwdata;
    } ApbRequest_t;

    typedef struct packed {
        ApbData_t prdata;
        logic     pready;
        logic     pslverr;
    } ApbResponse_t;

    typedef struct packed {
        Coord_t x;
        Coord_t y;
        Coord_t width;
        Coord_t height;
        Pixel_t colour;
    } RectCommand_t;

    localparam ApbAddress_t ControlOffset  = 8'h00;
    localparam ApbAddress_t PositionOffset = 8'h04;
    localparam ApbAddress_t SizeOffset     = 8'h08;
    localparam ApbAddress_t ColourOffset   = 8'h0C;
    localparam ApbAddress_t StatusOffset   = 8'h10;

    localparam int StartBit         = 0; // CONTROL, write one to launch a fill
    localparam int ScanoutEnableBit = 1; // CONTROL
    localparam int BusyBit          = 0; // STATUS

endpackage

//--- common/frameSettings_settings.svh
`ifndef FRAME_SETTINGS_SVH
`define FRAME_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Bus and word widths

`define SRAM_DATA_WIDTH 16
`define COORD_WIDTH 8
`define APB_ADDRESS_WIDTH 8
`define APB_DATA_WIDTH 32

// ~~~~~~~~~~~~~~~~~~~~
// Frame geometry, both sides are powers of two

`define FRAME_WIDTH_LOG2 4
`define FRAME_HEIGHT_LOG2 3
`define FRAME_WIDTH (1 << `FRAME_WIDTH_LOG2)
`define FRAME_HEIGHT (1 << `FRAME_HEIGHT_LOG2)
`define FRAME_SIZE (`FRAME_WIDTH * `FRAME_HEIGHT) // Pixels in one frame

// Row number sits above the column number in a linear address
`define SRAM_ADDRESS_WIDTH (`FRAME_WIDTH_LOG2 + `FRAME_HEIGHT_LOG2)

`endif

//--- renderer/rectRenderer.sv
`include "frameSettings_settings.svh"

module rectRenderer (
    input  logic                   clk,
    input  logic                   rst,
    input  framePkg::RectCommand_t rectCommand,
    input  logic                   start,
    output logic                   rendering,
    output framePkg::SramRequest_t renderRequest,
    input  framePkg::SramResult_t  renderResult
);

    typedef enum logic {
        StateIdle,
        StateWrite
    } RenderState_t;

    RenderState_t state;

    // One bit wider so a large x plus width cannot wrap back into the frame
    logic [`COORD_WIDTH:0] columnSum;
    logic [`COORD_WIDTH:0] rowSum;
    framePkg::Coord_t      columnLimit;
    framePkg::Coord_t      rowLimit;
    logic                  emptyClip;
    logic                  lastColumn;
    logic                  lastRow;

    framePkg::Coord_t column;
    framePkg::Coord_t row;
    framePkg::Coord_t columnFirst;
    framePkg::Coord_t columnEnd;
    framePkg::Coord_t rowEnd;
    framePkg::Pixel_t colour;

    // ~~~~~~~~~~~~~~~~~~~~
    // Clipping

    assign columnSum = {1'b0, rectCommand.x} + {1'b0, rectCommand.width};
    assign rowSum    = {1'b0, rectCommand.y} + {1'b0, rectCommand.height};

    always_comb begin
        columnLimit = (columnSum > `FRAME_WIDTH) ? framePkg::Coord_t'(`FRAME_WIDTH)
                                                 : columnSum[`COORD_WIDTH-1:0];
        rowLimit    = (rowSum > `FRAME_HEIGHT) ? framePkg::Coord_t'(`FRAME_HEIGHT)
                                               : rowSum[`COORD_WIDTH-1:0];
    end

    // Zero size or an origin past the edge both leave nothing to draw
    assign emptyClip = (columnLimit <= rectCommand.x) || (rowLimit <= rectCommand.y);

    assign lastColumn = (column + 1'b1) == columnEnd;
    assign lastRow    = (row + 1'b1) == rowEnd;

    // ~~~~~~~~~~~~~~~~~~~~
    // Walk

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= StateIdle;
        end else begin
            case (state)
                StateIdle:
                    if (start && !emptyClip) state <= StateWrite;
                StateWrite:
                    if (renderResult.done && lastColumn && lastRow) state <= StateIdle;
                default:
                    state <= StateIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle) begin
            if (start) begin
                column      <= rectCommand.x;
                row         <= rectCommand.y;
                columnFirst <= rectCommand.x;
                columnEnd   <= columnLimit;
                rowEnd      <= rowLimit;
                colour      <= rectCommand.colour; // Later colour writes do not touch this fill
            end
        end else if (renderResult.done) begin
            if (lastColumn) begin
                column <= columnFirst;
                row    <= row + 1'b1;
            end else begin
                column <= column + 1'b1;
            end
        end
    end

    assign rendering = (state == StateWrite);

    assign renderRequest = '{
        address:     {row[`FRAME_HEIGHT_LOG2-1:0], column[`FRAME_WIDTH_LOG2-1:0]},
        writeData:   colour,
        writeEnable: 1'b1,
        valid:       state == StateWrite
    };

    // A done from the controller only answers a request that is still pending
    doneWhilePending: assert property (@(posedge clk) disable iff (rst)
        renderResult.done |-> renderRequest.valid)
        else $error("Render done without a pending request");

endmodule

//--- renderer/renderRegisters.sv
`include "frameSettings_settings.svh"

module renderRegisters (
    input  logic                   clk,
    input  logic                   rst,
    input  framePkg::ApbRequest_t  apbRequest,
    output framePkg::ApbResponse_t apbResponse,
    input  logic                   rendering,
    output framePkg::RectCommand_t rectCommand,
    output logic                   start,
    output logic                   scanoutEnable
);

    logic               access;
    logic               writeAccess;
    logic               busy;
    logic               knownOffset;
    logic               geometryWrite;
    logic               accessError;
    framePkg::ApbData_t readData;

    assign access      = apbRequest.psel && apbRequest.penable;
    assign writeAccess = access && apbRequest.pwrite;
    assign busy        = rendering || start; // Start covers the cycle before the renderer wakes

    always_comb begin
        knownOffset = 1'b1;
        readData    = '0;
        case (apbRequest.paddr)
            framePkg::ControlOffset:
                readData[framePkg::ScanoutEnableBit] = scanoutEnable;
            framePkg::PositionOffset:
                readData = framePkg::ApbData_t'({rectCommand.y, rectCommand.x});
            framePkg::SizeOffset:
                readData = framePkg::ApbData_t'({rectCommand.height, rectCommand.width});
            framePkg::ColourOffset:
                readData = framePkg::ApbData_t'(rectCommand.colour);
            framePkg::StatusOffset:
                readData[framePkg::BusyBit] = busy;
            default:
                knownOffset = 1'b0;
        endcase
    end

    // Anything that would move or relaunch the rectangle
    assign geometryWrite = (apbRequest.paddr == framePkg::PositionOffset)
                        || (apbRequest.paddr == framePkg::SizeOffset)
                        || (apbRequest.paddr == framePkg::ControlOffset
                            && apbRequest.pwdata[framePkg::StartBit]);

    assign accessError = access && (!knownOffset || (apbRequest.pwrite
                         && (apbRequest.paddr == framePkg::StatusOffset
                             || (busy && geometryWrite))));

    assign apbResponse = '{prdata: readData, pready: 1'b1, pslverr: accessError};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rectCommand   <= '0;
            start         <= 1'b0;
            scanoutEnable <= 1'b0;
        end else begin
            start <= 1'b0;
            if (writeAccess && !accessError) begin
                case (apbRequest.paddr)
                    framePkg::ControlOffset: begin
                        start         <= apbRequest.pwdata[framePkg::StartBit];
                        scanoutEnable <= apbRequest.pwdata[framePkg::ScanoutEnableBit];
                    end
                    framePkg::PositionOffset: begin
                        rectCommand.x <= apbRequest.pwdata[`COORD_WIDTH-1:0];
                        rectCommand.y <= apbRequest.pwdata[2*`COORD_WIDTH-1:`COORD_WIDTH];
                    end
                    framePkg::SizeOffset: begin
                        rectCommand.width  <= apbRequest.pwdata[`COORD_WIDTH-1:0];
                        rectCommand.height <= apbRequest.pwdata[2*`COORD_WIDTH-1:`COORD_WIDTH];
                    end
                    framePkg::ColourOffset:
                        rectCommand.colour <= apbRequest.pwdata[`SRAM_DATA_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Access phase must sit inside a selected transfer
    apbEnableInSelect: assert property (@(posedge clk) disable iff (rst)
        apbRequest.penable |-> apbRequest.psel)
        else $error("APB penable without psel");

endmodule

//--- source/frameSubsystem.sv
module frameSubsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  framePkg::ApbRequest_t  apbRequest,
    output framePkg::ApbResponse_t apbResponse,
    output framePkg::SramBus_t     sramBus,
    input  framePkg::Pixel_t       sramDataIn,
    output framePkg::Pixel_t       pixel,
    output logic                   pixelValid,
    output logic                   lineStart,
    output logic                   frameStart
);

    framePkg::RectCommand_t rectCommand;
    framePkg::SramRequest_t videoRequest;
    framePkg::SramRequest_t renderRequest;
    framePkg::SramResult_t  videoResult;
    framePkg::SramResult_t  renderResult;
    logic                   start;
    logic                   rendering;
    logic                   scanoutEnable;

    renderRegisters renderRegisters_inst (
        .clk           (clk),
        .rst           (rst),
        .apbRequest    (apbRequest),
        .apbResponse   (apbResponse),
        .rendering     (rendering),
        .rectCommand   (rectCommand),
        .start         (start),
        .scanoutEnable (scanoutEnable)
    );

    rectRenderer rectRenderer_inst (
        .clk           (clk),
        .rst           (rst),
        .rectCommand   (rectCommand),
        .start         (start),
        .rendering     (rendering),
        .renderRequest (renderRequest),
        .renderResult  (renderResult)
    );

    // Video side of the frame
    scanout scanout_inst (
        .clk           (clk),
        .rst           (rst),
        .scanoutEnable (scanoutEnable),
        .videoRequest  (videoRequest),
        .videoResult   (videoResult),
        .pixel         (pixel),
        .pixelValid    (pixelValid),
        .lineStart     (lineStart),
        .frameStart    (frameStart)
    );

    sramController sramController_inst (
        .clk           (clk),
        .rst           (rst),
        .sramBus       (sramBus),
        .sramDataIn    (sramDataIn),
        .videoRequest  (videoRequest),
        .renderRequest (renderRequest),
        .videoResult   (videoResult),
        .renderResult  (renderResult)
    );

endmodule

//--- source/scanout.sv
`include "frameSettings_settings.svh"

module scanout (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   scanoutEnable,
    output framePkg::SramRequest_t videoRequest,
    input  framePkg::SramResult_t  videoResult,
    output framePkg::Pixel_t       pixel,
    output logic                   pixelValid,
    output logic                   lineStart,
    output logic                   frameStart
);

    framePkg::SramAddress_t rasterAddress;
    logic                   reading;
    logic                   columnZero;

    assign columnZero = rasterAddress[`FRAME_WIDTH_LOG2-1:0] == '0;

    // ~~~~~~~~~~~~~~~~~~~~
    // Raster counter

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reading       <= 1'b0;
            rasterAddress <= '0;
            pixelValid    <= 1'b0;
            lineStart     <= 1'b0;
            frameStart    <= 1'b0;
        end else begin
            // Markers come from the address of the read that just finished
            pixelValid <= videoResult.done;
            lineStart  <= videoResult.done && columnZero;
            frameStart <= videoResult.done && (rasterAddress == '0);

            if (!reading) begin
                reading <= scanoutEnable;
            end else if (videoResult.done) begin
                // An outstanding read always completes before the engine stops
                reading <= scanoutEnable;
                // Frame size is a power of two so the counter wraps at frame end
                rasterAddress <= scanoutEnable ? rasterAddress + 1'b1 : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (videoResult.done) pixel <= videoResult.readData;
    end

    assign videoRequest = '{
        address:     rasterAddress,
        writeData:   '0,
        writeEnable: 1'b0,
        valid:       reading
    };

endmodule

//--- source/sramController.sv
module sramController (
    input  logic                   clk,
    input  logic                   rst,
    output framePkg::SramBus_t     sramBus,
    input  framePkg::Pixel_t       sramDataIn,
    input  framePkg::SramRequest_t videoRequest,
    input  framePkg::SramRequest_t renderRequest,
    output framePkg::SramResult_t  videoResult,
    output framePkg::SramResult_t  renderResult
);

    typedef enum logic [1:0] {
        StateInit,
        StateVideo,
        StateRender
    } SlotState_t;

    SlotState_t state, nextState;

    framePkg::SramRequest_t granted;
    framePkg::SramAddress_t pinAddress;
    framePkg::Pixel_t       pinData;
    logic                   pinWeN;
    logic                   pinOeN;
    logic                   pinDataEnable;
    logic                   videoDone;
    logic                   renderDone;

    // Fixed slots, one per cycle, no arbitration
    always_comb begin
        case (state)
            StateInit:   nextState = StateVideo;
            StateVideo:  nextState = StateRender;
            StateRender: nextState = StateVideo;
            default:     nextState = StateInit;
        endcase
    end

    always_comb begin
        case (state)
            StateVideo:  granted = videoRequest;
            StateRender: granted = renderRequest;
            default:     granted = '0; // Init slot stays idle
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Pin registers

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= StateInit;
            pinWeN        <= 1'b1;
            pinOeN        <= 1'b1;
            pinDataEnable <= 1'b0;
            videoDone     <= 1'b0;
            renderDone    <= 1'b0;
        end else begin
            state         <= nextState;
            pinWeN        <= !(granted.valid && granted.writeEnable);
            pinOeN        <= !(granted.valid && !granted.writeEnable);
            pinDataEnable <= granted.valid && granted.writeEnable;
            // Done rides alongside the pins for the cycle the SRAM holds the access
            videoDone     <= (state == StateVideo) && videoRequest.valid;
            renderDone    <= (state == StateRender) && renderRequest.valid;
        end
    end

    always_ff @(posedge clk) begin
        pinAddress <= granted.address;
        pinData    <= granted.writeData;
    end

    assign sramBus = '{
        address:    pinAddress,
        weN:        pinWeN,
        oeN:        pinOeN,
        dataOut:    pinData,
        dataEnable: pinDataEnable
    };

    // Read data is taken from the pad in the same cycle as done
    assign videoResult  = '{readData: sramDataIn, done: videoDone};
    assign renderResult = '{readData: sramDataIn, done: renderDone};

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks

    noBusFight: assert property (@(posedge clk) disable iff (rst)
        !(!sramBus.weN && !sramBus.oeN))
        else $error("SRAM read and write strobes active together");

    driveOnlyOnWrite: assert property (@(posedge clk) disable iff (rst)
        sramBus.dataEnable |-> !sramBus.weN)
        else $error("SRAM data driven outside a write");

endmodule

//--- src.f
+incdir+common
common/framePkg.sv
source/sramController.sv
renderer/renderRegisters.sv
renderer/rectRenderer.sv
source/scanout.sv
source/frameSubsystem.sv
testbench/sramModel.sv
testbench/frameSubsystemTb.sv

//--- testbench/frameSubsystemTb.sv
`include "frameSettings_settings.svh"

module frameSubsystemTb;

    localparam int ClockPeriod = 100;
    localparam int NumTests    = 8;
    // Every test may spend up to 8 cycles per pixel of the frame
    localparam int WatchdogCycles = (NumTests + 1) * `FRAME_SIZE * 8 + 16;

    typedef struct packed {
        framePkg::Coord_t x;
        framePkg::Coord_t y;
        framePkg::Coord_t width;
        framePkg::Coord_t height;
        framePkg::Pixel_t colour;
        logic             busyError; // Expected pslverr on a geometry write right after start
        logic             capture;
    } TestEntry_t;

    logic                   clk;
    logic                   rst;
    framePkg::ApbRequest_t  apbRequest;
    framePkg::ApbResponse_t apbResponse;
    framePkg::SramBus_t     sramBus;
    framePkg::Pixel_t       sramDataIn;
    framePkg::Pixel_t       pixel;
    logic                   pixelValid;
    logic                   lineStart;
    logic                   frameStart;

    TestEntry_t       testTable [NumTests];
    framePkg::Pixel_t shadowFrame [`FRAME_SIZE];
    logic [31:0]      lfsrState;
    logic             scanoutOn;
    int               errorCount;
    int               testErrors;
    int               checkCount;

    frameSubsystem frameSubsystem_inst (
        .clk         (clk),
        .rst         (rst),
        .apbRequest  (apbRequest),
        .apbResponse (apbResponse),
        .sramBus     (sramBus),
        .sramDataIn  (sramDataIn),
        .pixel       (pixel),
        .pixelValid  (pixelValid),
        .lineStart   (lineStart),
        .frameStart  (frameStart)
    );

    sramModel sramModel_inst (
        .sramBus    (sramBus),
        .sramDataIn (sramDataIn)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers

    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) lfsrState = lfsrState ^ 32'hD0000001;
            value = {value[14:0], outBit};
        end
        return value;
    endfunction

    function automatic TestEntry_t makeEntry(input int x, input int y, input int width,
                                             input int height, input logic busyError,
                                             input logic capture);
        TestEntry_t entry;
        entry.x         = framePkg::Coord_t'(x);
        entry.y         = framePkg::Coord_t'(y);
        entry.width     = framePkg::Coord_t'(width);
        entry.height    = framePkg::Coord_t'(height);
        entry.colour    = randomBits(`SRAM_DATA_WIDTH);
        entry.busyError = busyError;
        entry.capture   = capture;
        return entry;
    endfunction

    task automatic loadTable();
        // Columns are x, y, width, height, busy pslverr and the capture flag
        testTable[0] = makeEntry(2, 1, 5, 3, 1'b1, 1'b1);
        testTable[1] = makeEntry(4, 2, 6, 4, 1'b1, 1'b1);    // Overlaps the first
        testTable[2] = makeEntry(13, 5, 8, 6, 1'b1, 1'b0);   // Clipped at right and bottom
        testTable[3] = makeEntry(3, 3, 0, 4, 1'b0, 1'b1);    // Zero width
        testTable[4] = makeEntry(0, 7, 16, 1, 1'b1, 1'b0);
        testTable[5] = makeEntry(20, 2, 4, 4, 1'b0, 1'b0);   // Origin past the edge
        testTable[6] = makeEntry(10, 0, 3, 2, 1'b1, 1'b1);
        testTable[7] = makeEntry(250, 0, 10, 2, 1'b0, 1'b1); // Sum would wrap in 8 bits
    endtask

    // Pixels inside the clipped rectangle take the colour
    task automatic paintShadow(input TestEntry_t entry);
        int columnStop;
        int rowStop;
        columnStop = int'(entry.x) + int'(entry.width);
        rowStop    = int'(entry.y) + int'(entry.height);
        if (columnStop > `FRAME_WIDTH) columnStop = `FRAME_WIDTH;
        if (rowStop > `FRAME_HEIGHT) rowStop = `FRAME_HEIGHT;
        for (int row = int'(entry.y); row < rowStop; row++) begin
            for (int column = int'(entry.x); column < columnStop; column++) begin
                shadowFrame[row * `FRAME_WIDTH + column] = entry.colour;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // APB

    task automatic apbTransfer(input logic write, input framePkg::ApbAddress_t address,
                               input framePkg::ApbData_t data,
                               output framePkg::ApbResponse_t response);
        @(negedge clk);
        apbRequest = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: address, pwdata: data};
        @(negedge clk);
        apbRequest.penable = 1'b1;
        #(ClockPeriod / 4);
        response = apbResponse; // Middle of the access phase
        @(negedge clk);
        apbRequest = '0;
    endtask

    task automatic writeRegister(input framePkg::ApbAddress_t address,
                                 input framePkg::ApbData_t data,
                                 output framePkg::ApbResponse_t response);
        apbTransfer(1'b1, address, data, response);
    endtask

    task automatic readRegister(input framePkg::ApbAddress_t address,
                                output framePkg::ApbResponse_t response);
        apbTransfer(1'b0, address, '0, response);
    endtask

    function automatic framePkg::ApbResponse_t expectedResponse(input framePkg::ApbData_t data,
                                                                input logic error);
        return '{prdata: data, pready: 1'b1, pslverr: error};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks

    task automatic checkApb(input framePkg::ApbResponse_t actual,
                            input framePkg::ApbResponse_t expected,
                            input logic compareData, input string what);
        checkCount++;
        if (actual.pslverr !== expected.pslverr || actual.pready !== expected.pready
            || (compareData && actual.prdata !== expected.prdata)) begin
            $display("Fail at %0t: %s gave prdata %h pslverr %b, expected prdata %h pslverr %b",
                     $time, what, actual.prdata, actual.pslverr,
                     expected.prdata, expected.pslverr);
            testErrors++;
        end
    endtask

    task automatic checkPixel(input framePkg::Pixel_t actual, input logic actualLine,
                              input logic actualFrame, input framePkg::Pixel_t expected,
                              input logic expectedLine, input logic expectedFrame,
                              input int index);
        checkCount++;
        if (actual !== expected || actualLine !== expectedLine
            || actualFrame !== expectedFrame) begin
            $display("Fail at %0t: pixel %0d gave %h line %b frame %b, expected %h %b %b",
                     $time, index, actual, actualLine, actualFrame,
                     expected, expectedLine, expectedFrame);
            testErrors++;
        end
    endtask

    // Strobes only, address and data are undefined while the pins are idle
    task automatic checkSramBus(input framePkg::SramBus_t actual,
                                input framePkg::SramBus_t expected, input string what);
        checkCount++;
        if (actual.weN !== expected.weN || actual.oeN !== expected.oeN
            || actual.dataEnable !== expected.dataEnable) begin
            $display("Fail at %0t: %s gave weN %b oeN %b dataEnable %b, expected %b %b %b",
                     $time, what, actual.weN, actual.oeN, actual.dataEnable,
                     expected.weN, expected.oeN, expected.dataEnable);
            testErrors++;
        end
    endtask

    task automatic waitIdle();
        framePkg::ApbResponse_t response;
        readRegister(framePkg::StatusOffset, response);
        while (response.prdata[framePkg::BusyBit]) begin
            readRegister(framePkg::StatusOffset, response);
        end
        checkApb(response, expectedResponse('0, 1'b0), 1'b1, "STATUS after fill");
    endtask

    task automatic captureFrame();
        int index;
        @(negedge clk);
        while (!(pixelValid && frameStart)) @(negedge clk);
        index = 0;
        while (index < `FRAME_SIZE) begin
            if (pixelValid) begin
                checkPixel(pixel, lineStart, frameStart, shadowFrame[index],
                           (index % `FRAME_WIDTH) == 0, index == 0, index);
                index++;
            end
            @(negedge clk);
        end
        // The pixel after a full frame opens the next one
        while (!pixelValid) @(negedge clk);
        checkPixel(pixel, lineStart, frameStart, shadowFrame[0], 1'b1, 1'b1, 0);
    endtask

    task automatic reportTest(input string name);
        $display("Test %s finished with %0d errors", name, testErrors);
        errorCount += testErrors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence

    initial begin
        TestEntry_t             entry;
        framePkg::ApbResponse_t response;
        framePkg::ApbData_t     position;
        framePkg::ApbData_t     probe;
        framePkg::SramBus_t     idleBus;
        rst        = 1'b1;
        apbRequest = '0;
        lfsrState  = 32'h67ce2c91;
        scanoutOn  = 1'b0;
        errorCount = 0;
        checkCount = 0;
        idleBus    = '{address: '0, weN: 1'b1, oeN: 1'b1, dataOut: '0, dataEnable: 1'b0};
        for (int i = 0; i < `FRAME_SIZE; i++) shadowFrame[i] = '0;
        loadTable();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        testErrors = 0;
        checkSramBus(sramBus, idleBus, "SRAM pins after reset");
        writeRegister(framePkg::PositionOffset, 32'h0000_0302, response);
        checkApb(response, expectedResponse('0, 1'b0), 1'b0, "POSITION write");
        readRegister(framePkg::PositionOffset, response);
        checkApb(response, expectedResponse(32'h0000_0302, 1'b0), 1'b1, "POSITION read");
        writeRegister(framePkg::SizeOffset, 32'h0000_0504, response);
        checkApb(response, expectedResponse('0, 1'b0), 1'b0, "SIZE write");
        readRegister(framePkg::SizeOffset, response);
        checkApb(response, expectedResponse(32'h0000_0504, 1'b0), 1'b1, "SIZE read");
        writeRegister(framePkg::ColourOffset, 32'h0000_BEEF, response);
        checkApb(response, expectedResponse('0, 1'b0), 1'b0, "COLOUR write");
        readRegister(framePkg::ColourOffset, response);
        checkApb(response, expectedResponse(32'h0000_BEEF, 1'b0), 1'b1, "COLOUR read");
        readRegister(framePkg::ControlOffset, response);
        checkApb(response, expectedResponse('0, 1'b0), 1'b1, "CONTROL read");
        writeRegister(8'h14, 32'h1, response);
        checkApb(response, expectedResponse('0, 1'b1), 1'b0, "unknown offset write");
        readRegister(8'h14, response);
        checkApb(response, expectedResponse('0, 1'b1), 1'b0, "unknown offset read");
        writeRegister(framePkg::StatusOffset, 32'h1, response);
        checkApb(response, expectedResponse('0, 1'b1), 1'b0, "STATUS write");
        readRegister(framePkg::StatusOffset, response);
        checkApb(response, expectedResponse('0, 1'b0), 1'b1, "STATUS idle read");
        reportTest("registers");

        for (int t = 0; t < NumTests; t++) begin
            entry      = testTable[t];
            testErrors = 0;
            position   = {16'h0, entry.y, entry.x};
            writeRegister(framePkg::PositionOffset, position, response);
            checkApb(response, expectedResponse('0, 1'b0), 1'b0, "POSITION write");
            writeRegister(framePkg::SizeOffset, {16'h0, entry.height, entry.width}, response);
            checkApb(response, expectedResponse('0, 1'b0), 1'b0, "SIZE write");
            writeRegister(framePkg::ColourOffset, {16'h0, entry.colour}, response);
            checkApb(response, expectedResponse('0, 1'b0), 1'b0, "COLOUR write");
            readRegister(framePkg::SizeOffset, response);
            checkApb(response, expectedResponse({16'h0, entry.height, entry.width}, 1'b0),
                     1'b1, "SIZE read");
            readRegister(framePkg::ColourOffset, response);
            checkApb(response, expectedResponse({16'h0, entry.colour}, 1'b0),
                     1'b1, "COLOUR read");

            writeRegister(framePkg::ControlOffset, {30'h0, scanoutOn, 1'b1}, response);
            checkApb(response, expectedResponse('0, 1'b0), 1'b0, "start write");
            readRegister(framePkg::StatusOffset, response);
            checkApb(response, expectedResponse({31'h0, entry.busyError}, 1'b0), 1'b1,
                     "STATUS after start");

            // A move during the fill must bounce and leave the rectangle alone
            probe = {16'h0, framePkg::Coord_t'(entry.y + 8'd1),
                     framePkg::Coord_t'(entry.x + 8'd1)};
            writeRegister(framePkg::PositionOffset, probe, response);
            checkApb(response, expectedResponse('0, entry.busyError), 1'b0, "POSITION while busy");
            readRegister(framePkg::PositionOffset, response);
            checkApb(response, expectedResponse(entry.busyError ? position : probe, 1'b0), 1'b1,
                     "POSITION after probe");

            waitIdle();
            paintShadow(entry);
            if (entry.capture) begin
                if (!scanoutOn) begin
                    scanoutOn = 1'b1;
                    writeRegister(framePkg::ControlOffset, 32'h0000_0002, response);
                    checkApb(response, expectedResponse('0, 1'b0), 1'b0, "scanout enable");
                    readRegister(framePkg::ControlOffset, response);
                    checkApb(response, expectedResponse(32'h0000_0002, 1'b0), 1'b1,
                             "CONTROL read with scanout");
                end
                captureFrame();
            end
            reportTest($sformatf("fill %0d", t));
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", NumTests + 1, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- testbench/sramModel.sv
`include "frameSettings_settings.svh"

module sramModel (
    input  framePkg::SramBus_t sramBus,
    output framePkg::Pixel_t   sramDataIn
);

    framePkg::Pixel_t memory [`FRAME_SIZE];

    initial begin
        for (int i = 0; i < `FRAME_SIZE; i++) begin
            memory[i] = '0;
        end
    end

    // Level sensitive write, the controller holds address and data for the whole strobe
    always @(sramBus) begin
        if (!sramBus.weN && sramBus.dataEnable) begin
            memory[sramBus.address] = sramBus.dataOut;
        end
    end

    // Output floats to zero while the read strobe is idle
    assign sramDataIn = sramBus.oeN ? '0 : memory[sramBus.address];

endmodule
